// File: hw/alu_isa_pkg.sv
// ALU instruction set: operation enum, instruction field layout, immediate and tag widths
package alu_isa_pkg;

    // Operations executed by every processing element
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_SLT = 3'd7
    } alu_op_e;

    // Instruction word is {opcode[2:0], imm_flag, reserved[3:0], imm[7:0]}
    localparam int INSTR_W = 16;

    localparam int OPC_W        = 3;
    localparam int OPC_LSB      = INSTR_W - OPC_W;
    localparam int IMM_FLAG_BIT = OPC_LSB - 1;

    // Signed immediate sits in the low byte
    localparam int IMM_W   = 8;
    localparam int IMM_LSB = 0;

    localparam int TAG_W = 6;

endpackage

// File: hw/lane_geom_pkg.sv
// Lane geometry: data width, default lane/PE counts and latency, serializer state enum
package lane_geom_pkg;

    // Width of one SIMD lane
    localparam int DATA_W = 32;

    // Defaults picked up by the top level
    localparam int DEF_NUM_LANES  = 8;
    localparam int DEF_NUM_PES    = 2;
    localparam int DEF_PE_LATENCY = 2;

    // SER_BUSY means an instruction has issued some but not all of its batches
    typedef enum logic {
        SER_IDLE = 1'b0,
        SER_BUSY = 1'b1
    } ser_state_e;

endpackage

// File: hw/alu_decode.sv
// Registered decode stage producing the ALU operation and the B operand lanes
`timescale 1ns/1ps

module alu_decode #(
    parameter int NUM_LANES = lane_geom_pkg::DEF_NUM_LANES
) (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            in_valid,
    input  logic [alu_isa_pkg::INSTR_W-1:0]                 instr,
    input  logic [NUM_LANES-1:0][lane_geom_pkg::DATA_W-1:0] op_a,
    input  logic [NUM_LANES-1:0][lane_geom_pkg::DATA_W-1:0] op_b,
    input  logic [alu_isa_pkg::TAG_W-1:0]                   tag,
    output logic                                            in_ready,
    output logic                                            dec_valid,
    output alu_isa_pkg::alu_op_e                            dec_op,
    output logic [NUM_LANES-1:0][lane_geom_pkg::DATA_W-1:0] dec_a,
    output logic [NUM_LANES-1:0][lane_geom_pkg::DATA_W-1:0] dec_b,
    output logic [alu_isa_pkg::TAG_W-1:0]                   dec_tag,
    input  logic                                            ser_ready
);
    localparam int DATA_W = lane_geom_pkg::DATA_W;
    localparam int IMM_W  = alu_isa_pkg::IMM_W;

    logic              load;
    logic              imm_flag;
    logic [IMM_W-1:0]  imm;
    logic [DATA_W-1:0] imm_ext;

    assign imm_flag = instr[alu_isa_pkg::IMM_FLAG_BIT];
    assign imm      = instr[alu_isa_pkg::IMM_LSB +: IMM_W];
    assign imm_ext  = {{(DATA_W - IMM_W){imm[IMM_W-1]}}, imm};

    // The stage accepts when empty or when its held item leaves this cycle, never in reset
    assign in_ready = ~reset && (~dec_valid || ser_ready);
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dec_op  <= alu_isa_pkg::alu_op_e'(instr[alu_isa_pkg::OPC_LSB +: alu_isa_pkg::OPC_W]);
            dec_a   <= op_a;
            dec_tag <= tag;
            // An immediate instruction broadcasts the immediate into every B lane
            for (int i = 0; i < NUM_LANES; i++) begin
                dec_b[i] <= imm_flag ? imm_ext : op_b[i];
            end
        end
    end

endmodule

// File: hw/pe_array.sv
// Array of integer processing elements behind a fixed-depth enabled result pipeline
`timescale 1ns/1ps

module pe_array #(
    parameter int NUM_PES    = lane_geom_pkg::DEF_NUM_PES,
    parameter int PE_LATENCY = lane_geom_pkg::DEF_PE_LATENCY
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          pe_enable,
    input  alu_isa_pkg::alu_op_e                          pe_op,
    input  logic [NUM_PES-1:0][lane_geom_pkg::DATA_W-1:0] pe_a,
    input  logic [NUM_PES-1:0][lane_geom_pkg::DATA_W-1:0] pe_b,
    output logic [NUM_PES-1:0][lane_geom_pkg::DATA_W-1:0] pe_result
);
    localparam int DATA_W = lane_geom_pkg::DATA_W;

    logic [NUM_PES-1:0][DATA_W-1:0] pe_comb;
    logic [NUM_PES-1:0][DATA_W-1:0] pipe [PE_LATENCY];

    function automatic logic [DATA_W-1:0] pe_compute(
        input alu_isa_pkg::alu_op_e op,
        input logic [DATA_W-1:0]    a,
        input logic [DATA_W-1:0]    b
    );
        logic [4:0] shamt;
        shamt = b[4:0];
        case (op)
            alu_isa_pkg::OP_ADD: return a + b;
            alu_isa_pkg::OP_SUB: return a - b;
            alu_isa_pkg::OP_AND: return a & b;
            alu_isa_pkg::OP_OR:  return a | b;
            alu_isa_pkg::OP_XOR: return a ^ b;
            alu_isa_pkg::OP_SLL: return a << shamt;
            alu_isa_pkg::OP_SRL: return a >> shamt;
            default:             return {{(DATA_W - 1){1'b0}}, $signed(a) < $signed(b)};
        endcase
    endfunction

    always_comb begin
        for (int p = 0; p < NUM_PES; p++) begin
            pe_comb[p] = pe_compute(pe_op, pe_a[p], pe_b[p]);
        end
    end

    // The whole pipeline advances only on enabled cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < PE_LATENCY; s++) begin
                pipe[s] <= '0;
            end
        end else if (pe_enable) begin
            pipe[0] <= pe_comb;
            for (int s = 1; s < PE_LATENCY; s++) begin
                pipe[s] <= pipe[s-1];
            end
        end
    end

    assign pe_result = pipe[PE_LATENCY-1];

endmodule

// File: hw/lane_serializer.sv
// Lane serializer feeding batches to the PE array and reassembling full result vectors
`timescale 1ns/1ps

module lane_serializer #(
    parameter int NUM_LANES  = lane_geom_pkg::DEF_NUM_LANES,
    parameter int NUM_PES    = lane_geom_pkg::DEF_NUM_PES,
    parameter int PE_LATENCY = lane_geom_pkg::DEF_PE_LATENCY
) (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            dec_valid,
    input  alu_isa_pkg::alu_op_e                            dec_op,
    input  logic [NUM_LANES-1:0][lane_geom_pkg::DATA_W-1:0] dec_a,
    input  logic [NUM_LANES-1:0][lane_geom_pkg::DATA_W-1:0] dec_b,
    input  logic [alu_isa_pkg::TAG_W-1:0]                   dec_tag,
    output logic                                            ser_ready,
    output logic                                            pe_enable,
    output alu_isa_pkg::alu_op_e                            pe_op,
    output logic [NUM_PES-1:0][lane_geom_pkg::DATA_W-1:0]   pe_a,
    output logic [NUM_PES-1:0][lane_geom_pkg::DATA_W-1:0]   pe_b,
    input  logic [NUM_PES-1:0][lane_geom_pkg::DATA_W-1:0]   pe_result,
    output logic                                            ser_valid,
    output logic [NUM_LANES-1:0][lane_geom_pkg::DATA_W-1:0] ser_data,
    output logic [alu_isa_pkg::TAG_W-1:0]                   ser_tag,
    input  logic                                            buf_ready
);
    localparam int DATA_W = lane_geom_pkg::DATA_W;
    localparam int TAG_W  = alu_isa_pkg::TAG_W;

    logic                     enable;
    logic [PE_LATENCY-1:0]    valid_sr;
    logic [TAG_W-1:0]         tag_sr [PE_LATENCY];
    logic                     pe_valid;

    // Valid and tag walk beside the PE pipeline, so each result batch finds its owner
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sr <= '0;
        end else if (enable) begin
            valid_sr[0] <= dec_valid;
            for (int s = 1; s < PE_LATENCY; s++) begin
                valid_sr[s] <= valid_sr[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            tag_sr[0] <= dec_tag;
            for (int s = 1; s < PE_LATENCY; s++) begin
                tag_sr[s] <= tag_sr[s-1];
            end
        end
    end

    assign pe_valid  = valid_sr[PE_LATENCY-1];
    assign ser_tag   = tag_sr[PE_LATENCY-1];
    assign pe_enable = enable;
    assign pe_op     = dec_op;

    if (NUM_LANES != NUM_PES) begin : g_serialize

        localparam int BATCH_SIZE  = NUM_LANES / NUM_PES;
        localparam int BATCH_SIZEW = $clog2(BATCH_SIZE);

        logic [BATCH_SIZEW-1:0]    batch_in_idx;
        logic [BATCH_SIZEW-1:0]    batch_out_idx;
        logic [BATCH_SIZEW-1:0]    in_sel;
        logic                      batch_in_done;
        logic                      batch_out_done;
        lane_geom_pkg::ser_state_e state;

        logic [BATCH_SIZE-1:0][NUM_PES-1:0][DATA_W-1:0] data_r;
        logic [BATCH_SIZE-1:0][NUM_PES-1:0][DATA_W-1:0] data_n;

        // A fresh instruction always starts from batch zero
        assign in_sel = (state == lane_geom_pkg::SER_IDLE) ? '0 : batch_in_idx;

        for (genvar p = 0; p < NUM_PES; p++) begin : g_pe_lane
            assign pe_a[p] = dec_a[in_sel * NUM_PES + p];
            assign pe_b[p] = dec_b[in_sel * NUM_PES + p];
        end

        // Done flags are registered one batch early so they line up with the last batch
        always_ff @(posedge clk) begin
            if (reset) begin
                batch_in_idx   <= '0;
                batch_out_idx  <= '0;
                batch_in_done  <= 1'b0;
                batch_out_done <= 1'b0;
                state          <= lane_geom_pkg::SER_IDLE;
            end else if (enable) begin
                batch_in_idx   <= batch_in_idx + BATCH_SIZEW'(dec_valid);
                batch_out_idx  <= batch_out_idx + BATCH_SIZEW'(pe_valid);
                batch_in_done  <= dec_valid && (batch_in_idx == BATCH_SIZEW'(BATCH_SIZE - 2));
                batch_out_done <= pe_valid && (batch_out_idx == BATCH_SIZEW'(BATCH_SIZE - 2));
                if (dec_valid) begin
                    state <= batch_in_done ? lane_geom_pkg::SER_IDLE : lane_geom_pkg::SER_BUSY;
                end
            end
        end

        always_comb begin
            data_n = data_r;
            if (pe_valid) begin
                data_n[batch_out_idx] = pe_result;
            end
        end

        always_ff @(posedge clk) begin
            data_r <= data_n;
        end

        assign enable    = buf_ready || ~ser_valid;
        assign ser_ready = enable && batch_in_done;
        assign ser_valid = batch_out_done;
        assign ser_data  = data_n;

    end else begin : g_passthru

        // One batch per instruction, so nothing is ever partially issued
        assign pe_a      = dec_a;
        assign pe_b      = dec_b;
        assign enable    = buf_ready || ~ser_valid;
        assign ser_ready = enable;
        assign ser_valid = pe_valid;
        assign ser_data  = pe_result;

    end

endmodule

// File: hw/result_buffer.sv
// Two-entry elastic output buffer with registered head and a skid slot
`timescale 1ns/1ps

module result_buffer #(
    parameter int NUM_LANES = lane_geom_pkg::DEF_NUM_LANES
) (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            ser_valid,
    input  logic [NUM_LANES-1:0][lane_geom_pkg::DATA_W-1:0] ser_data,
    input  logic [alu_isa_pkg::TAG_W-1:0]                   ser_tag,
    output logic                                            buf_ready,
    output logic                                            out_valid,
    output logic [NUM_LANES-1:0][lane_geom_pkg::DATA_W-1:0] out_data,
    output logic [alu_isa_pkg::TAG_W-1:0]                   out_tag,
    input  logic                                            out_ready
);
    localparam int DATA_W = lane_geom_pkg::DATA_W;

    logic                           skid_valid;
    logic [NUM_LANES-1:0][DATA_W-1:0] skid_data;
    logic [alu_isa_pkg::TAG_W-1:0]  skid_tag;
    logic                           head_free;

    // The skid slot only fills when the head is full, so a full skid means both are full
    assign buf_ready = ~skid_valid;
    assign head_free = ~out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (head_free) begin
            out_valid  <= skid_valid || ser_valid;
            skid_valid <= 1'b0;
        end else if (ser_valid && buf_ready) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (head_free) begin
            // Older skid entry goes out first to keep results in order
            if (skid_valid) begin
                out_data <= skid_data;
                out_tag  <= skid_tag;
            end else if (ser_valid) begin
                out_data <= ser_data;
                out_tag  <= ser_tag;
            end
        end else if (ser_valid && buf_ready) begin
            skid_data <= ser_data;
            skid_tag  <= ser_tag;
        end
    end

endmodule

// File: hw/simd_alu_top.sv
// SIMD integer ALU top level wiring decode, serializer, PE array and result buffer
`timescale 1ns/1ps

module simd_alu_top #(
    parameter int NUM_LANES  = lane_geom_pkg::DEF_NUM_LANES,
    parameter int NUM_PES    = lane_geom_pkg::DEF_NUM_PES,
    parameter int PE_LATENCY = lane_geom_pkg::DEF_PE_LATENCY
) (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            in_valid,
    input  logic [alu_isa_pkg::INSTR_W-1:0]                 instr,
    input  logic [NUM_LANES-1:0][lane_geom_pkg::DATA_W-1:0] op_a,
    input  logic [NUM_LANES-1:0][lane_geom_pkg::DATA_W-1:0] op_b,
    input  logic [alu_isa_pkg::TAG_W-1:0]                   tag,
    output logic                                            in_ready,
    output logic                                            out_valid,
    output logic [NUM_LANES-1:0][lane_geom_pkg::DATA_W-1:0] out_data,
    output logic [alu_isa_pkg::TAG_W-1:0]                   out_tag,
    input  logic                                            out_ready
);
    localparam int DATA_W = lane_geom_pkg::DATA_W;
    localparam int TAG_W  = alu_isa_pkg::TAG_W;

    // Decode to serializer
    logic                             dec_valid;
    alu_isa_pkg::alu_op_e             dec_op;
    logic [NUM_LANES-1:0][DATA_W-1:0] dec_a;
    logic [NUM_LANES-1:0][DATA_W-1:0] dec_b;
    logic [TAG_W-1:0]                 dec_tag;
    logic                             ser_ready;

    // Serializer to PE array
    logic                             pe_enable;
    alu_isa_pkg::alu_op_e             pe_op;
    logic [NUM_PES-1:0][DATA_W-1:0]   pe_a;
    logic [NUM_PES-1:0][DATA_W-1:0]   pe_b;
    logic [NUM_PES-1:0][DATA_W-1:0]   pe_result;

    // Serializer to result buffer
    logic                             ser_valid;
    logic [NUM_LANES-1:0][DATA_W-1:0] ser_data;
    logic [TAG_W-1:0]                 ser_tag;
    logic                             buf_ready;

    alu_decode #(
        .NUM_LANES (NUM_LANES)
    ) u_dec (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .instr     (instr),
        .op_a      (op_a),
        .op_b      (op_b),
        .tag       (tag),
        .in_ready  (in_ready),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_a     (dec_a),
        .dec_b     (dec_b),
        .dec_tag   (dec_tag),
        .ser_ready (ser_ready)
    );

    lane_serializer #(
        .NUM_LANES  (NUM_LANES),
        .NUM_PES    (NUM_PES),
        .PE_LATENCY (PE_LATENCY)
    ) u_ser (
        .clk       (clk),
        .reset     (reset),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_a     (dec_a),
        .dec_b     (dec_b),
        .dec_tag   (dec_tag),
        .ser_ready (ser_ready),
        .pe_enable (pe_enable),
        .pe_op     (pe_op),
        .pe_a      (pe_a),
        .pe_b      (pe_b),
        .pe_result (pe_result),
        .ser_valid (ser_valid),
        .ser_data  (ser_data),
        .ser_tag   (ser_tag),
        .buf_ready (buf_ready)
    );

    pe_array #(
        .NUM_PES    (NUM_PES),
        .PE_LATENCY (PE_LATENCY)
    ) u_pe (
        .clk       (clk),
        .reset     (reset),
        .pe_enable (pe_enable),
        .pe_op     (pe_op),
        .pe_a      (pe_a),
        .pe_b      (pe_b),
        .pe_result (pe_result)
    );

    result_buffer #(
        .NUM_LANES (NUM_LANES)
    ) u_buf (
        .clk       (clk),
        .reset     (reset),
        .ser_valid (ser_valid),
        .ser_data  (ser_data),
        .ser_tag   (ser_tag),
        .buf_ready (buf_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_tag   (out_tag),
        .out_ready (out_ready)
    );

endmodule

// File: tests/simd_alu_properties.sv
// Concurrent handshake assertions for simd_alu_top and the bind that attaches them
`timescale 1ns/1ps

module simd_alu_properties #(
    parameter int NUM_LANES = lane_geom_pkg::DEF_NUM_LANES
) (
    input logic                                            clk,
    input logic                                            reset,
    input logic                                            in_valid,
    input logic                                            in_ready,
    input logic [alu_isa_pkg::INSTR_W-1:0]                 instr,
    input logic [alu_isa_pkg::TAG_W-1:0]                   tag,
    input logic                                            out_valid,
    input logic                                            out_ready,
    input logic [NUM_LANES-1:0][lane_geom_pkg::DATA_W-1:0] out_data,
    input logic [alu_isa_pkg::TAG_W-1:0]                   out_tag
);

    // A stalled result keeps its valid, lanes and tag until it is taken
    out_stable_a: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_tag))
        else $error("out_valid or result changed while stalled");

    // An offered instruction stays offered and unchanged until accepted
    in_hold_a: assert property (@(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid && $stable(instr) && $stable(tag))
        else $error("in_valid dropped or instruction changed before acceptance");

    out_reset_a: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high after a reset cycle");

endmodule

bind simd_alu_top simd_alu_properties #(
    .NUM_LANES (NUM_LANES)
) u_props (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .instr     (instr),
    .tag       (tag),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_tag   (out_tag)
);

// File: tests/simd_alu_tb.sv
// Testbench for simd_alu_top: clock, reset, directed tests, reference model, checks and timeout
`timescale 1ns/1ps

module simd_alu_tb;

    localparam int NUM_LANES        = lane_geom_pkg::DEF_NUM_LANES;
    localparam int DATA_W           = lane_geom_pkg::DATA_W;
    localparam int TAG_W            = alu_isa_pkg::TAG_W;
    localparam int INSTR_W          = alu_isa_pkg::INSTR_W;
    localparam int CLK_PERIOD       = 4;
    localparam int MAX_INSTRS       = 60;
    localparam int CYCLES_PER_INSTR = 16;
    localparam int TIMEOUT_CYCLES   = MAX_INSTRS * CYCLES_PER_INSTR + 200;

    typedef logic [NUM_LANES-1:0][DATA_W-1:0] lanes_t;

    logic               clk;
    logic               reset;
    logic               in_valid;
    logic [INSTR_W-1:0] instr;
    lanes_t             op_a;
    lanes_t             op_b;
    logic [TAG_W-1:0]   tag;
    logic               in_ready;
    logic               out_valid;
    lanes_t             out_data;
    logic [TAG_W-1:0]   out_tag;
    logic               out_ready;

    integer seed;
    logic   bp_mode;
    int     cycle_count;
    int     max_pending;

    // Expected results in acceptance order
    lanes_t               exp_data_q[$];
    logic [TAG_W-1:0]     exp_tag_q[$];
    alu_isa_pkg::alu_op_e exp_op_q[$];

    simd_alu_top #(
        .NUM_LANES  (NUM_LANES),
        .NUM_PES    (lane_geom_pkg::DEF_NUM_PES),
        .PE_LATENCY (lane_geom_pkg::DEF_PE_LATENCY)
    ) dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .instr     (instr),
        .op_a      (op_a),
        .op_b      (op_b),
        .tag       (tag),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_tag   (out_tag),
        .out_ready (out_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    // One lane of the ALU, written from the operation definitions
    function automatic logic [DATA_W-1:0] ref_lane(input alu_isa_pkg::alu_op_e op,
                                                   input logic [DATA_W-1:0] a,
                                                   input logic [DATA_W-1:0] b);
        int signed   sa;
        int signed   sb;
        int unsigned sh;
        sa = a;
        sb = b;
        sh = b % 32;
        case (op)
            alu_isa_pkg::OP_ADD: return a + b;
            alu_isa_pkg::OP_SUB: return a - b;
            alu_isa_pkg::OP_AND: return a & b;
            alu_isa_pkg::OP_OR:  return a | b;
            alu_isa_pkg::OP_XOR: return a ^ b;
            alu_isa_pkg::OP_SLL: return a << sh;
            alu_isa_pkg::OP_SRL: return a >> sh;
            alu_isa_pkg::OP_SLT: return (sa < sb) ? 32'd1 : 32'd0;
            default:             return 'x;
        endcase
    endfunction

    function automatic alu_isa_pkg::alu_op_e opcode_of(input logic [INSTR_W-1:0] word);
        return alu_isa_pkg::alu_op_e'(word[INSTR_W-1 -: 3]);
    endfunction

    // The immediate flag sits just below the opcode and replaces B in every lane
    function automatic lanes_t ref_vector(input logic [INSTR_W-1:0] word,
                                          input lanes_t a, input lanes_t b);
        lanes_t            res;
        logic [DATA_W-1:0] imm_ext;
        imm_ext = DATA_W'($signed(word[7:0]));
        for (int i = 0; i < NUM_LANES; i++) begin
            res[i] = ref_lane(opcode_of(word), a[i], word[INSTR_W-4] ? imm_ext : b[i]);
        end
        return res;
    endfunction

    function automatic logic [INSTR_W-1:0] make_instr(input alu_isa_pkg::alu_op_e op,
                                                      input logic imm_flag,
                                                      input logic [7:0] imm);
        return {op, imm_flag, 4'b0000, imm};
    endfunction

    function automatic lanes_t random_lanes();
        lanes_t v;
        for (int i = 0; i < NUM_LANES; i++) begin
            v[i] = $random(seed);
        end
        return v;
    endfunction

    task automatic check_op_result(input alu_isa_pkg::alu_op_e op, input int lane,
                                   input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] got);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: lane %0d op %s expected %h got %h",
                                $time, lane, op.name(), exp, got));
        end
    endtask

    task automatic check_lanes(input alu_isa_pkg::alu_op_e op, input lanes_t exp,
                               input lanes_t got);
        for (int i = 0; i < NUM_LANES; i++) begin
            check_op_result(op, i, exp[i], got[i]);
        end
    endtask

    task automatic check_tag(input logic [TAG_W-1:0] exp, input logic [TAG_W-1:0] got);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: out_tag expected %0d got %0d",
                                $time, exp, got));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s expected %b got %b",
                                $time, name, exp, got));
        end
    endtask

    // Handshakes are sampled on the falling edge, where every input and output is settled
    always @(negedge clk) begin
        if (!reset && out_valid && out_ready) begin
            if (exp_tag_q.size() == 0) begin
                abort_run("An output transfer happened with no instruction outstanding");
            end else begin
                check_tag(exp_tag_q[0], out_tag);
                check_lanes(exp_op_q[0], exp_data_q[0], out_data);
                void'(exp_tag_q.pop_front());
                void'(exp_op_q.pop_front());
                void'(exp_data_q.pop_front());
            end
        end
        if (!reset && in_valid && in_ready) begin
            exp_data_q.push_back(ref_vector(instr, op_a, op_b));
            exp_tag_q.push_back(tag);
            exp_op_q.push_back(opcode_of(instr));
            if (exp_tag_q.size() > max_pending) begin
                max_pending = exp_tag_q.size();
            end
        end
    end

    // Random back-pressure when enabled, otherwise the sink is always ready
    always @(posedge clk) begin
        #1;
        if (bp_mode) begin
            out_ready = ($random(seed) & 1) != 0;
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: the run did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    // Called at 1 ns after a rising edge and returns at the same point after acceptance
    task automatic send_instr(input logic [INSTR_W-1:0] word, input lanes_t a,
                              input lanes_t b, input logic [TAG_W-1:0] t);
        in_valid = 1'b1;
        instr    = word;
        op_a     = a;
        op_b     = b;
        tag      = t;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_tag_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic reset_idle_test();
        repeat (10) begin
            @(posedge clk);
            #1;
            check_flag("out_valid during reset", 1'b0, out_valid);
            check_flag("in_ready during reset", 1'b0, in_ready);
        end
        reset = 1'b0;
        @(negedge clk);
        check_flag("in_ready after reset", 1'b1, in_ready);
        check_flag("out_valid after reset", 1'b0, out_valid);
        @(posedge clk);
        #1;
    endtask

    task automatic opcode_sweep_test();
        for (int op = 0; op < 8; op++) begin
            send_instr(make_instr(alu_isa_pkg::alu_op_e'(op), 1'b0, 8'h00),
                       random_lanes(), random_lanes(), TAG_W'(op));
            drain();
        end
    endtask

    task automatic immediate_test();
        alu_isa_pkg::alu_op_e ops[4] = '{alu_isa_pkg::OP_ADD, alu_isa_pkg::OP_SUB,
                                         alu_isa_pkg::OP_SLT, alu_isa_pkg::OP_SRL};
        logic [7:0]           imms[4] = '{8'h05, 8'hf0, 8'h80, 8'h7f};
        for (int i = 0; i < 4; i++) begin
            send_instr(make_instr(ops[i], 1'b1, imms[i]), random_lanes(), random_lanes(),
                       TAG_W'(i + 8));
            drain();
        end
    endtask

    // Operands are drawn before back-pressure starts so the random sequence stays fixed
    task automatic stream_test(input int count, input int tag_base, input logic use_bp);
        logic [INSTR_W-1:0]   words[$];
        lanes_t               a_q[$];
        lanes_t               b_q[$];
        alu_isa_pkg::alu_op_e op;
        logic                 imm_flag;
        logic [7:0]           imm;
        for (int i = 0; i < count; i++) begin
            op       = alu_isa_pkg::alu_op_e'($random(seed) & 7);
            imm_flag = ($random(seed) & 1) != 0;
            imm      = 8'($random(seed));
            words.push_back(make_instr(op, imm_flag, imm));
            a_q.push_back(random_lanes());
            b_q.push_back(random_lanes());
        end
        max_pending = 0;
        if (use_bp) begin
            @(negedge clk);
            bp_mode = 1'b1;
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < count; i++) begin
            send_instr(words[i], a_q[i], b_q[i], TAG_W'(tag_base + i));
        end
        drain();
        @(negedge clk);
        bp_mode = 1'b0;
        @(posedge clk);
        #1;
    endtask

    initial begin
        seed        = 32'hf8a2;
        clk         = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        instr       = '0;
        op_a        = '0;
        op_b        = '0;
        tag         = '0;
        out_ready   = 1'b1;
        bp_mode     = 1'b0;
        cycle_count = 0;
        max_pending = 0;

        reset_idle_test();
        opcode_sweep_test();
        immediate_test();
        stream_test(20, 16, 1'b0);
        if (max_pending < 2) begin
            abort_run("The back-to-back stream never had two instructions in flight");
        end
        stream_test(20, 40, 1'b1);

        // With every result delivered the DUT holds no output and accepts again
        @(negedge clk);
        if (!out_valid && in_ready) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("The DUT did not return to idle after the last result");
        end
    end

endmodule

// File: build.f
hw/alu_isa_pkg.sv
hw/lane_geom_pkg.sv
hw/alu_decode.sv
hw/pe_array.sv
hw/lane_serializer.sv
hw/result_buffer.sv
hw/simd_alu_top.sv
tests/simd_alu_properties.sv
tests/simd_alu_tb.sv

// File: Bender.yml
package:
  name: simd_alu

sources:
  # Packages first, then the design from the leaves up to the top level
  - files:
      - hw/alu_isa_pkg.sv
      - hw/lane_geom_pkg.sv
      - hw/alu_decode.sv
      - hw/pe_array.sv
      - hw/lane_serializer.sv
      - hw/result_buffer.sv
      - hw/simd_alu_top.sv

  # Verification sources with simd_alu_tb as the simulation top
  - target: test
    files:
      - tests/simd_alu_properties.sv
      - tests/simd_alu_tb.sv
